// ==== hw/freq_mon_macros.svh ====
// channel count, data widths, prescale factor and register map offsets for the frequency monitor
`ifndef FREQ_MON_MACROS_SVH
`define FREQ_MON_MACROS_SVH

// number of measured clock inputs
`define FM_NUM_CH 4
// width of the per-channel tally and latched count
`define FM_CNT_W 20
// width of the programmable measurement window, in ref_clk cycles
`define FM_WIN_W 24
// measured clock rising edges per prescaler toggle
`define FM_PRESCALE 8
// depth of the toggle synchronizer into ref_clk
`define FM_SYNC_STAGES 3
// window length loaded at reset
`define FM_WIN_RESET 1000

// register byte offsets on the APB port
`define FM_REG_CTRL 8'h00
`define FM_REG_STATUS 8'h04
`define FM_REG_WINDOW 8'h08
`define FM_REG_CH_EN 8'h0C
`define FM_REG_WIN_CNT 8'h10
// count registers start here, one word per channel
`define FM_REG_COUNT0 8'h20

`endif

// ==== hw/freq_mon_pkg.sv ====
// vector types for counts, window length, channel mask and APB fields, plus the sequencer states
`include "freq_mon_macros.svh"

package freq_mon_pkg;

	// tally and latched count, in prescale periods per window
	typedef logic [`FM_CNT_W-1:0] count_t;

	// window length in ref_clk cycles
	typedef logic [`FM_WIN_W-1:0] window_t;

	// one enable bit per measured channel
	typedef logic [`FM_NUM_CH-1:0] ch_mask_t;

	// register port address and data
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// measurement sequencer states
	typedef enum logic [1:0] {
		IDLE,
		ARM,
		MEASURE,
		LATCH
	} fsm_state_t;

endpackage

// ==== hw/freq_mon_timebase.sv ====
// window timer counting ref_clk cycles up to the programmed window length
`timescale 1ns/1ns
`include "freq_mon_macros.svh"

module freq_mon_timebase (
	input  logic                  ref_clk,
	input  logic                  arst_n,
	input  logic                  clr,
	input  logic                  run,
	input  freq_mon_pkg::window_t window_len,
	output logic                  window_end
);

	// cycles of run since the last clear
	freq_mon_pkg::window_t cnt;
	// value of cnt in the last cycle of the window
	freq_mon_pkg::window_t last_cnt;
	freq_mon_pkg::window_t next_cnt;
	// counter has reached the end and now holds there
	logic hit;
	// a window of zero or one cycle ends in the first run cycle
	logic short_window;

	assign last_cnt = window_len - freq_mon_pkg::window_t'(1);
	assign next_cnt = cnt + freq_mon_pkg::window_t'(1);
	assign hit = (cnt == last_cnt);
	assign short_window = (window_len <= freq_mon_pkg::window_t'(1));

	// window_end is raised together with cnt reaching last_cnt, so it lands
	// on the window_len-th cycle of run counted from the clear
	always_ff @(posedge ref_clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			window_end <= 1'b0;
		end else if (clr) begin
			cnt <= '0;
			// with cnt already at its last value the very next run cycle ends the window
			window_end <= short_window;
		end else if (run && !hit) begin
			cnt <= next_cnt;
			window_end <= (next_cnt == last_cnt);
		end else begin
			// the count holds at the end until the next clear, and the flag is a single pulse
			window_end <= 1'b0;
		end
	end

endmodule

// ==== hw/freq_mon_ctrl_fsm.sv ====
// measurement sequencer that arms, runs, latches and optionally repeats windows
`timescale 1ns/1ns

module freq_mon_ctrl_fsm (
	input  logic ref_clk,
	input  logic arst_n,
	input  logic start,
	input  logic continuous,
	input  logic window_end,
	output logic busy,
	output logic tally_clr,
	output logic timer_run,
	output logic latch
);

	freq_mon_pkg::fsm_state_t state;
	freq_mon_pkg::fsm_state_t next_state;

	// state register
	always_ff @(posedge ref_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= freq_mon_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	// next state logic
	// start is only looked at in IDLE, so a start while busy is dropped
	always_comb begin
		next_state = state;
		case (state)
			freq_mon_pkg::IDLE: begin
				if (start) begin
					next_state = freq_mon_pkg::ARM;
				end
			end
			freq_mon_pkg::ARM: begin
				// one cycle to clear the tallies and the timer
				next_state = freq_mon_pkg::MEASURE;
			end
			freq_mon_pkg::MEASURE: begin
				// window_end arrives in the last of window_len cycles here
				if (window_end) begin
					next_state = freq_mon_pkg::LATCH;
				end
			end
			freq_mon_pkg::LATCH: begin
				// continuous mode goes straight back for the next window,
				// so clearing continuous lets the current window finish first
				if (continuous) begin
					next_state = freq_mon_pkg::ARM;
				end else begin
					next_state = freq_mon_pkg::IDLE;
				end
			end
			default: begin
				next_state = freq_mon_pkg::IDLE;
			end
		endcase
	end

	// outputs decode straight from the state register
	assign busy = (state != freq_mon_pkg::IDLE);
	assign tally_clr = (state == freq_mon_pkg::ARM);
	assign timer_run = (state == freq_mon_pkg::MEASURE);
	// the latch pulse doubles as the window_done strobe to the registers
	assign latch = (state == freq_mon_pkg::LATCH);

endmodule

// ==== hw/freq_mon_channel.sv ====
// one measured channel with prescaler, toggle synchronizer, edge detect, tally and latched count
`timescale 1ns/1ns
`include "freq_mon_macros.svh"

module freq_mon_channel (
	input  logic                 ref_clk,
	input  logic                 arst_n,
	input  logic                 meas_clk,
	input  logic                 en,
	input  logic                 tally_clr,
	input  logic                 latch,
	output freq_mon_pkg::count_t count
);

	// prescaler width, kept at one bit for a prescale of one
	localparam int PRE_W = ($clog2(`FM_PRESCALE) > 0) ? $clog2(`FM_PRESCALE) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`FM_PRESCALE - 1);

	// meas_clk domain
	logic [PRE_W-1:0] pre_cnt;
	logic pre_toggle;

	// ref_clk domain
	logic [`FM_SYNC_STAGES-1:0] sync_q;
	logic prescale_event;
	freq_mon_pkg::count_t tally;
	logic tally_full;

	// the prescaler runs on the measured clock itself and flips the toggle
	// once every FM_PRESCALE rising edges
	always_ff @(posedge meas_clk or negedge arst_n) begin
		if (!arst_n) begin
			pre_cnt <= '0;
			pre_toggle <= 1'b0;
		end else if (pre_cnt == PRE_LAST) begin
			pre_cnt <= '0;
			pre_toggle <= ~pre_toggle;
		end else begin
			pre_cnt <= pre_cnt + PRE_W'(1);
		end
	end

	// the toggle changes slowly compared with ref_clk, so a plain shift
	// chain is enough to bring it across
	always_ff @(posedge ref_clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[`FM_SYNC_STAGES-2:0], pre_toggle};
		end
	end

	// any change between the last two stages is one prescale period
	assign prescale_event = sync_q[`FM_SYNC_STAGES-1] ^ sync_q[`FM_SYNC_STAGES-2];

	// stop at the top instead of wrapping on a very fast input
	assign tally_full = (tally == '1);

	// tally of prescale periods in the running window
	always_ff @(posedge ref_clk or negedge arst_n) begin
		if (!arst_n) begin
			tally <= '0;
		end else if (tally_clr) begin
			tally <= '0;
		end else if (en && prescale_event && !tally_full) begin
			tally <= tally + freq_mon_pkg::count_t'(1);
		end
	end

	// result of the finished window, held until the next latch
	always_ff @(posedge ref_clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (latch) begin
			count <= tally;
		end
	end

endmodule

// ==== hw/freq_mon_apb_regs.sv ====
// APB register file with control, status, window length, channel mask, window count and counts
`timescale 1ns/1ns
`include "freq_mon_macros.svh"

module freq_mon_apb_regs (
	input  logic                                       ref_clk,
	input  logic                                       arst_n,
	input  freq_mon_pkg::apb_addr_t                    paddr,
	input  logic                                       psel,
	input  logic                                       penable,
	input  logic                                       pwrite,
	input  freq_mon_pkg::apb_data_t                    pwdata,
	output freq_mon_pkg::apb_data_t                    prdata,
	output logic                                       pready,
	output logic                                       pslverr,
	output logic                                       start,
	output logic                                       continuous,
	output freq_mon_pkg::window_t                      window_len,
	output freq_mon_pkg::ch_mask_t                     ch_en,
	input  logic                                       busy,
	input  logic                                       window_done,
	input  freq_mon_pkg::count_t [`FM_NUM_CH-1:0]      counts,
	output logic                                       irq
);

	logic access;
	logic wr_access;
	logic rd_access;
	// address decode
	logic sel_ctrl;
	logic sel_status;
	logic sel_window;
	logic sel_ch_en;
	logic sel_win_cnt;
	logic sel_count;
	freq_mon_pkg::apb_addr_t count_off;
	logic mapped;
	logic read_only;
	logic wr_ok;
	// register state
	logic irq_en;
	logic done;
	freq_mon_pkg::apb_data_t win_cnt;

	// the access phase of a transfer, writes land at its closing edge
	assign access = psel & penable;
	assign wr_access = access & pwrite;
	assign rd_access = access & ~pwrite;

	assign sel_ctrl = (paddr == `FM_REG_CTRL);
	assign sel_status = (paddr == `FM_REG_STATUS);
	assign sel_window = (paddr == `FM_REG_WINDOW);
	assign sel_ch_en = (paddr == `FM_REG_CH_EN);
	assign sel_win_cnt = (paddr == `FM_REG_WIN_CNT);

	// count registers are word aligned, one per channel from COUNT0
	assign count_off = paddr - `FM_REG_COUNT0;
	assign sel_count = (paddr >= `FM_REG_COUNT0) && (count_off[1:0] == 2'b00) &&
		(count_off[7:2] < 6'(`FM_NUM_CH));

	assign mapped = sel_ctrl | sel_status | sel_window | sel_ch_en | sel_win_cnt | sel_count;
	assign read_only = sel_win_cnt | sel_count;
	// a rejected write changes nothing
	assign wr_ok = wr_access & mapped & ~read_only;

	// no wait states on this port
	assign pready = 1'b1;
	assign pslverr = access & (~mapped | (pwrite & read_only));

	// control and configuration registers
	always_ff @(posedge ref_clk or negedge arst_n) begin
		if (!arst_n) begin
			start <= 1'b0;
			continuous <= 1'b0;
			irq_en <= 1'b0;
			window_len <= freq_mon_pkg::window_t'(`FM_WIN_RESET);
			ch_en <= '1;
		end else begin
			// start is a single cycle strobe and is never stored
			start <= wr_ok & sel_ctrl & pwdata[0];
			if (wr_ok && sel_ctrl) begin
				continuous <= pwdata[1];
				irq_en <= pwdata[2];
			end
			if (wr_ok && sel_window) begin
				window_len <= pwdata[`FM_WIN_W-1:0];
			end
			if (wr_ok && sel_ch_en) begin
				ch_en <= pwdata[`FM_NUM_CH-1:0];
			end
		end
	end

	// done is sticky, a new window_done wins over a clear in the same cycle
	always_ff @(posedge ref_clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
			win_cnt <= '0;
		end else begin
			if (window_done) begin
				done <= 1'b1;
			end else if (wr_ok && sel_status && pwdata[1]) begin
				done <= 1'b0;
			end
			if (window_done) begin
				win_cnt <= win_cnt + freq_mon_pkg::apb_data_t'(1);
			end
		end
	end

	assign irq = done & irq_en;

	// read mux, the start bit always reads back as zero
	always_comb begin
		prdata = '0;
		if (rd_access) begin
			if (sel_ctrl) begin
				prdata[2:0] = {irq_en, continuous, 1'b0};
			end else if (sel_status) begin
				prdata[1:0] = {done, busy};
			end else if (sel_window) begin
				prdata[`FM_WIN_W-1:0] = window_len;
			end else if (sel_ch_en) begin
				prdata[`FM_NUM_CH-1:0] = ch_en;
			end else if (sel_win_cnt) begin
				prdata = win_cnt;
			end else if (sel_count) begin
				prdata[`FM_CNT_W-1:0] = counts[count_off[7:2]];
			end
		end
	end

endmodule

// ==== hw/freq_mon_top.sv ====
// frequency monitor top level with register file, sequencer, window timer and channels
`timescale 1ns/1ns
`include "freq_mon_macros.svh"

module freq_mon_top (
	input  logic                    ref_clk,
	input  logic                    arst_n,
	input  logic [`FM_NUM_CH-1:0]   meas_clk,
	input  freq_mon_pkg::apb_addr_t paddr,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  freq_mon_pkg::apb_data_t pwdata,
	output freq_mon_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    irq
);

	// register file to sequencer and channels
	logic start;
	logic continuous;
	freq_mon_pkg::window_t window_len;
	freq_mon_pkg::ch_mask_t ch_en;
	// sequencer outputs
	logic busy;
	logic tally_clr;
	logic timer_run;
	logic latch;
	logic window_end;
	// latched results of all channels
	freq_mon_pkg::count_t [`FM_NUM_CH-1:0] counts;

	freq_mon_apb_regs u_regs (
		.ref_clk(ref_clk), .arst_n(arst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .continuous(continuous), .window_len(window_len), .ch_en(ch_en),
		.busy(busy), .window_done(latch), .counts(counts), .irq(irq)
	);

	freq_mon_ctrl_fsm u_ctrl_fsm (
		.ref_clk(ref_clk), .arst_n(arst_n), .start(start), .continuous(continuous),
		.window_end(window_end), .busy(busy), .tally_clr(tally_clr),
		.timer_run(timer_run), .latch(latch)
	);

	// the same clear that resets the tallies restarts the timer
	freq_mon_timebase u_timebase (
		.ref_clk(ref_clk), .arst_n(arst_n), .clr(tally_clr), .run(timer_run),
		.window_len(window_len), .window_end(window_end)
	);

	// one channel per measured clock, all sharing the window strobes
	for (genvar i = 0; i < `FM_NUM_CH; i++) begin : g_ch
		freq_mon_channel u_channel (
			.ref_clk(ref_clk), .arst_n(arst_n), .meas_clk(meas_clk[i]), .en(ch_en[i]),
			.tally_clr(tally_clr), .latch(latch), .count(counts[i])
		);
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// reference clock source and power-on reset generator for the testbench
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic ref_clk,
	output logic arst_n
);

	// free-running reference clock, half a period per phase
	initial begin
		ref_clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			ref_clk = ~ref_clk;
		end
	end

	// reset is released on a falling edge so it never races the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge ref_clk);
		@(negedge ref_clk);
		arst_n = 1'b1;
	end

endmodule

// ==== testbench/tb_freq_mon.sv ====
// testbench for the frequency monitor with APB tasks, measured clocks, LFSR and checks
`timescale 1ns/1ns
`include "freq_mon_macros.svh"

module tb_freq_mon;

	localparam int REF_PERIOD_NS = 4;
	localparam int APB_TIMEOUT = 16;
	localparam int IRQ_TIMEOUT = 5000;
	localparam int POLL_LIMIT = 2000;
	localparam int RUN_LIMIT = 40000;

	logic ref_clk;
	logic arst_n;
	wire [`FM_NUM_CH-1:0] meas_clk;
	freq_mon_pkg::apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	freq_mon_pkg::apb_data_t pwdata;
	freq_mon_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic irq;
	// sequencer state for the timeout messages
	freq_mon_pkg::fsm_state_t seq_state;

	int errors = 0;
	int prop_errors = 0;
	int checks = 0;
	// rising edges of ref_clk since time zero
	int cyc = 0;
	// irq_en as last written over the bus
	logic irq_en_model = 1'b0;
	logic [16:0] lfsr_state = 17'd79532;
	// measured clock period of each channel in ns
	int meas_period [`FM_NUM_CH] = '{default: 10};

	tb_clock_gen #(.PERIOD_NS(REF_PERIOD_NS), .RESET_CYCLES(2)) u_clock_gen (
		.ref_clk(ref_clk), .arst_n(arst_n)
	);

	freq_mon_top u_freq_mon_top (
		.ref_clk(ref_clk), .arst_n(arst_n), .meas_clk(meas_clk),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .irq(irq)
	);

	assign seq_state = u_freq_mon_top.u_ctrl_fsm.state;

	always @(posedge ref_clk) begin
		cyc <= cyc + 1;
	end

	// each measured clock runs on its own and an odd period spends the longer half high
	for (genvar g = 0; g < `FM_NUM_CH; g++) begin : g_meas
		logic clk_q = 1'b0;
		initial begin
			forever begin
				#(meas_period[g] / 2);
				clk_q = 1'b1;
				#(meas_period[g] - meas_period[g] / 2);
				clk_q = 1'b0;
			end
		end
		assign meas_clk[g] = clk_q;
	end

	// bus protocol rules that hold on every cycle
	pready_high: assert property (@(posedge ref_clk) disable iff (!arst_n) pready)
	else begin
		prop_errors++;
		$display("** Error: pready got 0x%0h expected 0x1", pready);
	end
	pslverr_in_access: assert property (@(posedge ref_clk) disable iff (!arst_n)
		pslverr |-> (psel && penable))
	else begin
		prop_errors++;
		$display("** Error: pslverr got 0x1 outside an access cycle, expected 0x0");
	end
	irq_needs_en: assert property (@(posedge ref_clk) disable iff (!arst_n) irq |-> irq_en_model)
	else begin
		prop_errors++;
		$display("** Error: irq got 0x1 expected 0x0 while irq_en is clear");
	end

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors + prop_errors);
		if (errors + prop_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	task automatic abort_run(input string reason);
		errors++;
		$display("timeout while %s, sequencer in state %s", reason, seq_state.name());
		finish_run();
	endtask

	// Fibonacci LFSR x^17 + x^14 + 1 stepped once per bit
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[16] ^ lfsr_state[13];
		lfsr_state = {lfsr_state[15:0], fb};
		return fb;
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_step());
		end
		return v;
	endfunction

	// periods between 3 and 17 ns
	task automatic pick_periods();
		for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
			meas_period[ch] = 3 + random_bits(4) % 15;
		end
	endtask

	// whole prescale periods that fit in the window
	function automatic int expected_count(input int window, input int period);
		return (window * REF_PERIOD_NS) / (period * `FM_PRESCALE);
	endfunction

	task automatic check_value(input string name, input freq_mon_pkg::apb_data_t got,
		input freq_mon_pkg::apb_data_t exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_near(input string name, input freq_mon_pkg::apb_data_t got,
		input int exp);
		checks++;
		assert ((int'(got) >= exp - 1) && (int'(got) <= exp + 1)) else begin
			errors++;
			$display("** Error: %s got 0x%0h expected 0x%0h +/- 1", name, got, exp);
		end
	endtask

	// one APB transfer of a setup and an access cycle that returns on the falling edge after it
	task automatic apb_transfer(input freq_mon_pkg::apb_addr_t addr, input logic write,
		input freq_mon_pkg::apb_data_t data, output freq_mon_pkg::apb_data_t rd,
		output logic err);
		int waited;
		waited = 0;
		@(negedge ref_clk);
		paddr = addr;
		pwrite = write;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge ref_clk);
		penable = 1'b1;
		#1;
		while (!pready) begin
			if (waited >= APB_TIMEOUT) begin
				abort_run("waiting for pready on the APB port");
			end
			@(negedge ref_clk);
			#1;
			waited++;
		end
		rd = prdata;
		err = pslverr;
		@(negedge ref_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		if (write && addr == `FM_REG_CTRL && !err) begin
			irq_en_model = data[2];
		end
	endtask

	task automatic apb_write(input freq_mon_pkg::apb_addr_t addr,
		input freq_mon_pkg::apb_data_t data, output logic err);
		freq_mon_pkg::apb_data_t unused_rd;
		apb_transfer(addr, 1'b1, data, unused_rd, err);
	endtask

	task automatic apb_read(input freq_mon_pkg::apb_addr_t addr,
		output freq_mon_pkg::apb_data_t rd, output logic err);
		apb_transfer(addr, 1'b0, '0, rd, err);
	endtask

	task automatic read_check(input string name, input freq_mon_pkg::apb_addr_t addr,
		input freq_mon_pkg::apb_data_t exp);
		freq_mon_pkg::apb_data_t rd;
		logic err;
		apb_read(addr, rd, err);
		check_value(name, rd, exp);
	endtask

	// masked channels must read zero and the others follow the period rule
	task automatic check_counts(input int window, input freq_mon_pkg::ch_mask_t mask);
		freq_mon_pkg::apb_data_t rd;
		logic err;
		for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
			apb_read(`FM_REG_COUNT0 + freq_mon_pkg::apb_addr_t'(4 * ch), rd, err);
			if (mask[ch]) begin
				check_near($sformatf("COUNT%0d", ch), rd, expected_count(window, meas_period[ch]));
			end else begin
				check_value($sformatf("COUNT%0d", ch), rd, 0);
			end
		end
	endtask

	// reset counts as released only once arst_n is a clean one
	task automatic wait_reset();
		int waited;
		waited = 0;
		while (arst_n !== 1'b1) begin
			if (waited >= POLL_LIMIT) begin
				abort_run("waiting for reset release");
			end
			@(negedge ref_clk);
			waited++;
		end
	endtask

	// irq is sampled on falling edges and at_cyc is the cycle where it was first seen
	task automatic wait_irq(input string what, output int at_cyc);
		int waited;
		waited = 0;
		while (!irq) begin
			if (waited >= IRQ_TIMEOUT) begin
				abort_run($sformatf("waiting for irq after %s", what));
			end
			@(negedge ref_clk);
			waited++;
		end
		at_cyc = cyc;
	endtask

	task automatic wait_status(input freq_mon_pkg::apb_data_t mask,
		input freq_mon_pkg::apb_data_t value, input string what);
		int polls;
		freq_mon_pkg::apb_data_t rd;
		logic err;
		polls = 0;
		apb_read(`FM_REG_STATUS, rd, err);
		while ((rd & mask) != value) begin
			if (polls >= POLL_LIMIT) begin
				abort_run(what);
			end
			apb_read(`FM_REG_STATUS, rd, err);
			polls++;
		end
	endtask

	// a continuous window ends window + 2 cycles after the previous one
	task automatic next_window(input int window, inout int last);
		int now;
		logic err;
		wait_irq("a continuous window", now);
		check_value("window period", freq_mon_pkg::apb_data_t'(now - last),
			freq_mon_pkg::apb_data_t'(window + 2));
		last = now;
		apb_write(`FM_REG_STATUS, 32'h2, err);
	endtask

	initial begin : watchdog
		int n;
		n = 0;
		while (n < RUN_LIMIT) begin
			@(posedge ref_clk);
			n++;
		end
		abort_run("running the whole test sequence");
	end

	initial begin
		freq_mon_pkg::apb_data_t rd;
		freq_mon_pkg::apb_data_t cnt0;
		logic err;
		int t_start;
		int t_last;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		wait_reset();

		// reset values
		check_value("irq", freq_mon_pkg::apb_data_t'(irq), 0);
		read_check("STATUS", `FM_REG_STATUS, 0);
		read_check("WIN_CNT", `FM_REG_WIN_CNT, 0);
		read_check("WINDOW", `FM_REG_WINDOW, 1000);
		check_counts(0, '0);

		// single window with the interrupt enabled
		pick_periods();
		apb_write(`FM_REG_WINDOW, 400, err);
		check_value("pslverr", freq_mon_pkg::apb_data_t'(err), 0);
		apb_write(`FM_REG_CH_EN, 32'hF, err);
		apb_write(`FM_REG_CTRL, 32'h5, err);
		t_start = cyc;
		read_check("STATUS", `FM_REG_STATUS, 32'h1);
		wait_irq("a single window", t_last);
		check_value("done delay", freq_mon_pkg::apb_data_t'(t_last - t_start), 403);
		check_counts(400, 4'hF);
		read_check("WIN_CNT", `FM_REG_WIN_CNT, 1);
		apb_write(`FM_REG_STATUS, 32'h2, err);
		check_value("irq", freq_mon_pkg::apb_data_t'(irq), 0);

		// masked channels and done without irq_en before irq_en is turned on late
		apb_write(`FM_REG_CH_EN, 32'h5, err);
		apb_write(`FM_REG_CTRL, 32'h1, err);
		wait_status(32'h2, 32'h2, "waiting for done of the masked window");
		check_value("irq", freq_mon_pkg::apb_data_t'(irq), 0);
		check_counts(400, 4'h5);
		apb_write(`FM_REG_CTRL, 32'h4, err);
		check_value("irq", freq_mon_pkg::apb_data_t'(irq), 1);
		apb_write(`FM_REG_STATUS, 32'h2, err);
		check_value("irq", freq_mon_pkg::apb_data_t'(irq), 0);
		read_check("STATUS", `FM_REG_STATUS, 0);
		read_check("WIN_CNT", `FM_REG_WIN_CNT, 2);

		// continuous windows with an extra start that the busy sequencer drops
		apb_write(`FM_REG_WINDOW, 200, err);
		apb_write(`FM_REG_CH_EN, 32'hF, err);
		apb_write(`FM_REG_CTRL, 32'h7, err);
		t_start = cyc;
		wait_irq("the first continuous window", t_last);
		check_value("done delay", freq_mon_pkg::apb_data_t'(t_last - t_start), 203);
		apb_write(`FM_REG_STATUS, 32'h2, err);
		apb_write(`FM_REG_CTRL, 32'h7, err);
		next_window(200, t_last);
		next_window(200, t_last);
		check_counts(200, 4'hF);
		// the window that spans the change is mixed and only the one after it is checked
		pick_periods();
		next_window(200, t_last);
		next_window(200, t_last);
		check_counts(200, 4'hF);
		read_check("WIN_CNT", `FM_REG_WIN_CNT, 7);
		apb_write(`FM_REG_CTRL, 32'h4, err);
		apb_read(`FM_REG_STATUS, rd, err);
		check_value("busy", rd & 32'h1, 32'h1);
		wait_status(32'h1, 32'h0, "waiting for busy to fall after continuous was cleared");
		read_check("WIN_CNT", `FM_REG_WIN_CNT, 8);

		// rejected writes leave the registers alone
		apb_write(8'h14, 32'h1, err);
		check_value("pslverr", freq_mon_pkg::apb_data_t'(err), 1);
		apb_write(`FM_REG_WIN_CNT, 32'h55, err);
		check_value("pslverr", freq_mon_pkg::apb_data_t'(err), 1);
		read_check("WIN_CNT", `FM_REG_WIN_CNT, 8);
		apb_read(`FM_REG_COUNT0, cnt0, err);
		apb_write(`FM_REG_COUNT0, 32'hABCDE, err);
		check_value("pslverr", freq_mon_pkg::apb_data_t'(err), 1);
		read_check("COUNT0", `FM_REG_COUNT0, cnt0);

		finish_run();
	end

endmodule

// ==== sources.f ====
+incdir+hw
hw/freq_mon_pkg.sv
hw/freq_mon_timebase.sv
hw/freq_mon_ctrl_fsm.sv
hw/freq_mon_channel.sv
hw/freq_mon_apb_regs.sv
hw/freq_mon_top.sv
testbench/tb_clock_gen.sv
testbench/tb_freq_mon.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the frequency monitor testbench with Verilator, run it and scan the log

verilator --binary --timing -f sources.f --top-module tb_freq_mon \
	-Mdir obj_dir -o sim_freq_mon > build.log 2>&1 \
	&& ./obj_dir/sim_freq_mon > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log \
	&& { echo "simulation failed, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
